//--- src/dreq_consts.svh
`ifndef DREQ_CONSTS_SVH
`define DREQ_CONSTS_SVH

`define DREQ_FIFO_DEPTH  8
`define DREQ_THRESHOLD   4   // Group size that raises DREQ0

`define DREQ_OFF_DCR     6'h06
`define DREQ_OFF_DSARH   6'h08
`define DREQ_OFF_DSARL   6'h0A
`define DREQ_OFF_DDARH   6'h0C
`define DREQ_OFF_DDARL   6'h0E
`define DREQ_OFF_DLR     6'h10
`define DREQ_OFF_FIFO    6'h12

`define DREQ_DCR_MASK    16'h0007
`define DREQ_ADDRH_MASK  8'hFF
`define DREQ_ADDRL_MASK  16'hFFFE   // DMA addresses are word aligned
`define DREQ_DLR_MASK    16'hFFFF

`define DREQ_DCR_RV      0
`define DREQ_DCR_DMA     1
`define DREQ_DCR_M68S    2
`define DREQ_DCR_FULL    7   // Full flag in 68000 reads

`endif

//--- src/dreqPkg.sv
`default_nettype none

package dreqPkg;

	// Data word on either bus and in the FIFO
	typedef logic [15:0] word_t;

	// Byte offset in the system register block, {A[5:1],1'b0}
	typedef logic [5:0] regOff_t;

	// DMA source or destination address
	typedef logic [23:0] dmaAddr_t;

	// Fill count 0..8
	typedef logic [3:0] fifoCount_t;

endpackage

`default_nettype wire

//--- src/mdDreqRegs.sv
`default_nettype none

`include "dreq_consts.svh"

module mdDreqRegs (
	input  wire                 CLK,
	input  wire                 RST_N,

	input  wire dreqPkg::regOff_t   va,
	input  wire dreqPkg::word_t     vdi,
	input  wire                 mdSel,
	input  wire                 asN,
	input  wire                 lwrN,
	input  wire                 uwrN,
	input  wire                 cas0N,
	output dreqPkg::word_t      vdo,
	output logic                dtackN,

	input  wire dreqPkg::fifoCount_t fifoCount,
	output logic                fifoPush,
	output dreqPkg::word_t      fifoWData,
	output logic                fifoFlush,

	output dreqPkg::word_t      dcr,
	output dreqPkg::dmaAddr_t   dsar,
	output dreqPkg::dmaAddr_t   ddar,
	output dreqPkg::word_t      dlr
);
	import dreqPkg::*;

	logic   mdAccess;
	logic   mdWrite;
	logic   fifoFull;
	word_t  laneMask;
	word_t  dlrNext;
	word_t  fullFlag;
	word_t  rdData;

	// New 68000 cycle, DTACK not yet given
	assign mdAccess = mdSel && !asN && (!lwrN || !uwrN || !cas0N) && dtackN;
	assign mdWrite  = !lwrN || !uwrN;
	assign fifoFull = (fifoCount == `DREQ_FIFO_DEPTH);
	assign laneMask = {{8{!uwrN}}, {8{!lwrN}}};
	assign dlrNext  = dlr - 16'd1;

	always_comb begin
		fullFlag = '0;
		fullFlag[`DREQ_DCR_FULL] = fifoFull;
		case (va)
			`DREQ_OFF_DCR:   rdData = (dcr & `DREQ_DCR_MASK) | fullFlag;
			`DREQ_OFF_DSARH: rdData = {8'h00, dsar[23:16]};
			`DREQ_OFF_DSARL: rdData = dsar[15:0];
			`DREQ_OFF_DDARH: rdData = {8'h00, ddar[23:16]};
			`DREQ_OFF_DDARL: rdData = ddar[15:0];
			`DREQ_OFF_DLR:   rdData = dlr;
			`DREQ_OFF_FIFO:  rdData = '0;   // Write only port
			default:         rdData = '0;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			dtackN    <= 1'b1;
			fifoPush  <= 1'b0;
			fifoFlush <= 1'b0;
			dcr       <= '0;
			dsar      <= '0;
			ddar      <= '0;
			dlr       <= '0;
		end else begin
			fifoPush  <= 1'b0;
			fifoFlush <= 1'b0;
			if (mdAccess) begin
				dtackN <= 1'b0;
				if (mdWrite) begin
					case (va)
						`DREQ_OFF_DCR: begin
							dcr <= (dcr & ~laneMask) | (vdi & `DREQ_DCR_MASK & laneMask);
							// Clearing M68S drops whatever is buffered
							if (!lwrN && !vdi[`DREQ_DCR_M68S]) begin
								fifoFlush <= 1'b1;
							end
						end
						`DREQ_OFF_DSARH: begin
							if (!lwrN) dsar[23:16] <= vdi[7:0] & `DREQ_ADDRH_MASK;
						end
						`DREQ_OFF_DSARL: begin
							dsar[15:0] <= (dsar[15:0] & ~laneMask) |
								(vdi & `DREQ_ADDRL_MASK & laneMask);
						end
						`DREQ_OFF_DDARH: begin
							if (!lwrN) ddar[23:16] <= vdi[7:0] & `DREQ_ADDRH_MASK;
						end
						`DREQ_OFF_DDARL: begin
							ddar[15:0] <= (ddar[15:0] & ~laneMask) |
								(vdi & `DREQ_ADDRL_MASK & laneMask);
						end
						`DREQ_OFF_DLR: begin
							dlr <= (dlr & ~laneMask) | (vdi & `DREQ_DLR_MASK & laneMask);
						end
						`DREQ_OFF_FIFO: begin
							// Dropped when full or transfer not armed, still acked
							if (dcr[`DREQ_DCR_M68S] && !fifoFull) begin
								fifoPush <= 1'b1;
								dlr      <= dlrNext;
								if (dlrNext == '0) dcr[`DREQ_DCR_M68S] <= 1'b0;
							end
						end
						default: ;
					endcase
				end
			end else if (asN && !dtackN) begin
				dtackN <= 1'b1;   // Cycle over
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (mdAccess && mdWrite) fifoWData <= vdi;
		if (mdAccess && !mdWrite) vdo <= rdData;
	end

endmodule

`default_nettype wire

//--- src/dreqFifo.sv
`default_nettype none

`include "dreq_consts.svh"

module dreqFifo (
	input  wire                 CLK,
	input  wire                 RST_N,

	input  wire                 fifoPush,
	input  wire                 fifoPop,
	input  wire                 fifoFlush,
	input  wire dreqPkg::word_t     fifoWData,
	output dreqPkg::word_t      fifoRData,
	output dreqPkg::fifoCount_t fifoCount
);
	import dreqPkg::*;

	word_t  mem [`DREQ_FIFO_DEPTH];
	logic [$clog2(`DREQ_FIFO_DEPTH)-1:0] wrPtr;
	logic [$clog2(`DREQ_FIFO_DEPTH)-1:0] rdPtr;
	logic   full;
	logic   empty;
	logic   doPush;
	logic   doPop;

	assign full   = (fifoCount == `DREQ_FIFO_DEPTH);
	assign empty  = (fifoCount == '0);
	assign doPush = fifoPush && !full && !fifoFlush;
	assign doPop  = fifoPop && !empty && !fifoFlush;

	assign fifoRData = mem[rdPtr];   // Head word

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wrPtr     <= '0;
			rdPtr     <= '0;
			fifoCount <= '0;
		end else if (fifoFlush) begin
			wrPtr     <= '0;
			rdPtr     <= '0;
			fifoCount <= '0;
		end else begin
			if (doPush) wrPtr <= wrPtr + 1'b1;   // Wraps at depth
			if (doPop) rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10:   fifoCount <= fifoCount + 4'd1;
				2'b01:   fifoCount <= fifoCount - 4'd1;
				default: ;   // Idle, or push and pop together
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (doPush) mem[wrPtr] <= fifoWData;
	end

endmodule

`default_nettype wire

//--- src/shDreqPort.sv
`default_nettype none

`include "dreq_consts.svh"

module shDreqPort (
	input  wire                 CLK,
	input  wire                 RST_N,

	input  wire                 shSel,
	input  wire dreqPkg::regOff_t   shA,
	input  wire                 shRdN,
	output dreqPkg::word_t      shDo,
	output logic                dreq0N,

	input  wire dreqPkg::word_t     fifoRData,
	input  wire dreqPkg::fifoCount_t fifoCount,
	output logic                fifoPop,

	input  wire dreqPkg::word_t     dcr,
	input  wire dreqPkg::dmaAddr_t  dsar,
	input  wire dreqPkg::dmaAddr_t  ddar,
	input  wire dreqPkg::word_t     dlr
);
	import dreqPkg::*;

	logic   rdDone;
	logic   rdStrobe;
	logic   fifoFull;
	logic   fifoEmpty;
	logic   dreqLevel;
	word_t  status;
	word_t  rdData;

	// One strobe per low phase of the read line
	assign rdStrobe  = shSel && !shRdN && !rdDone;
	assign fifoPop   = rdStrobe && (shA == `DREQ_OFF_FIFO);
	assign fifoFull  = (fifoCount == `DREQ_FIFO_DEPTH);
	assign fifoEmpty = (fifoCount == '0);
	assign dreqLevel = (fifoCount >= `DREQ_THRESHOLD) && dcr[`DREQ_DCR_DMA];

	always_comb begin
		status = '0;
		status[15] = fifoFull;
		status[14] = fifoEmpty;
		status[`DREQ_DCR_M68S] = dcr[`DREQ_DCR_M68S];
		status[`DREQ_DCR_DMA]  = dcr[`DREQ_DCR_DMA];
		status[`DREQ_DCR_RV]   = dcr[`DREQ_DCR_RV];

		case (shA)
			`DREQ_OFF_DCR:   rdData = status;
			`DREQ_OFF_DSARH: rdData = {8'h00, dsar[23:16]};
			`DREQ_OFF_DSARL: rdData = dsar[15:0];
			`DREQ_OFF_DDARH: rdData = {8'h00, ddar[23:16]};
			`DREQ_OFF_DDARL: rdData = ddar[15:0];
			`DREQ_OFF_DLR:   rdData = dlr;
			`DREQ_OFF_FIFO:  rdData = fifoRData;   // Popped on this edge
			default:         rdData = '0;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rdDone <= 1'b0;
			dreq0N <= 1'b1;
		end else begin
			if (shRdN) begin
				rdDone <= 1'b0;
			end else if (rdStrobe) begin
				rdDone <= 1'b1;
			end
			dreq0N <= !dreqLevel;   // Follows count one cycle late
		end
	end

	// Held until the next read
	always_ff @(posedge CLK) begin
		if (rdStrobe) shDo <= rdData;
	end

endmodule

`default_nettype wire

//--- src/dreqTop.sv
`default_nettype none

module dreqTop (
	input  wire                 CLK,
	input  wire                 RST_N,

	// 68000 side
	input  wire dreqPkg::regOff_t   va,
	input  wire dreqPkg::word_t     vdi,
	output dreqPkg::word_t      vdo,
	input  wire                 asN,
	input  wire                 lwrN,
	input  wire                 uwrN,
	input  wire                 cas0N,
	input  wire                 mdSel,
	output logic                dtackN,

	// SH2 side
	input  wire                 shSel,
	input  wire dreqPkg::regOff_t   shA,
	input  wire                 shRdN,
	output dreqPkg::word_t      shDo,
	output logic                dreq0N
);
	import dreqPkg::*;

	logic        fifoPush;
	logic        fifoPop;
	logic        fifoFlush;
	word_t       fifoWData;
	word_t       fifoRData;
	fifoCount_t  fifoCount;
	word_t       dcr;
	dmaAddr_t    dsar;
	dmaAddr_t    ddar;
	word_t       dlr;

	mdDreqRegs mdRegs_i (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.va        (va),
		.vdi       (vdi),
		.mdSel     (mdSel),
		.asN       (asN),
		.lwrN      (lwrN),
		.uwrN      (uwrN),
		.cas0N     (cas0N),
		.vdo       (vdo),
		.dtackN    (dtackN),
		.fifoCount (fifoCount),
		.fifoPush  (fifoPush),
		.fifoWData (fifoWData),
		.fifoFlush (fifoFlush),
		.dcr       (dcr),
		.dsar      (dsar),
		.ddar      (ddar),
		.dlr       (dlr)
	);

	dreqFifo fifo_i (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.fifoPush  (fifoPush),
		.fifoPop   (fifoPop),
		.fifoFlush (fifoFlush),
		.fifoWData (fifoWData),
		.fifoRData (fifoRData),
		.fifoCount (fifoCount)
	);

	shDreqPort shPort_i (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.shSel     (shSel),
		.shA       (shA),
		.shRdN     (shRdN),
		.shDo      (shDo),
		.dreq0N    (dreq0N),
		.fifoRData (fifoRData),
		.fifoCount (fifoCount),
		.fifoPop   (fifoPop),
		.dcr       (dcr),
		.dsar      (dsar),
		.ddar      (ddar),
		.dlr       (dlr)
	);

endmodule

`default_nettype wire

//--- verif/tbDreq.sv
`default_nettype none

`include "dreq_consts.svh"

module tbDreq;
	import dreqPkg::*;

	localparam int timeoutCycles = 50;
	localparam regOff_t regOffs [6] = '{`DREQ_OFF_DCR, `DREQ_OFF_DSARH, `DREQ_OFF_DSARL,
		`DREQ_OFF_DDARH, `DREQ_OFF_DDARL, `DREQ_OFF_DLR};

	logic     CLK;
	logic     RST_N;
	regOff_t  va;
	word_t    vdi;
	word_t    vdo;
	logic     asN;
	logic     lwrN;
	logic     uwrN;
	logic     cas0N;
	logic     mdSel;
	logic     dtackN;
	logic     shSel;
	regOff_t  shA;
	logic     shRdN;
	word_t    shDo;
	logic     dreq0N;

	int          errCount = 0;
	int          testCount = 0;
	logic [31:0] lfsr = 32'h7333_4a65;
	word_t       expDcr = '0;   // Reference model of the DUT state
	word_t       expDlr = '0;
	word_t       fifoModel [$];

	dreqTop dut_i (.*);

	initial CLK = 1'b0;
	always #2 CLK = ~CLK;

	assert property (@(posedge CLK) disable iff (!RST_N)
		(mdSel && !asN && (!lwrN || !uwrN || !cas0N) && dtackN) |=> !dtackN)
	else begin
		errCount++;
		$display("error %0t: dtackN not low one cycle after the access", $time);
	end

	assert property (@(posedge CLK) disable iff (!RST_N) (asN && !dtackN) |=> dtackN)
	else begin
		errCount++;
		$display("error %0t: dtackN still low after asN rose", $time);
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic randWord(output word_t w);
		for (int i = 0; i < 16; i++) begin
			lfsr = lfsrStep(lfsr);
			w = {w[14:0], lfsr[0]};
		end
	endtask

	function automatic word_t mdStatus();
		word_t s = expDcr & `DREQ_DCR_MASK;
		s[`DREQ_DCR_FULL] = (fifoModel.size() == `DREQ_FIFO_DEPTH);
		return s;
	endfunction

	function automatic word_t shStatus();
		word_t s = '0;
		s[15] = (fifoModel.size() == `DREQ_FIFO_DEPTH);
		s[14] = (fifoModel.size() == 0);
		s[2:0] = expDcr[2:0];
		return s;
	endfunction

	function automatic word_t regExpect(input regOff_t off, input word_t w, input logic sh);
		case (off)
			`DREQ_OFF_DCR:                    return sh ? shStatus() : mdStatus();
			`DREQ_OFF_DSARH, `DREQ_OFF_DDARH: return {8'h00, w[7:0] & `DREQ_ADDRH_MASK};
			`DREQ_OFF_DSARL, `DREQ_OFF_DDARL: return w & `DREQ_ADDRL_MASK;
			default:                          return w & `DREQ_DLR_MASK;
		endcase
	endfunction

	task automatic abortRun(input string why);
		$display("%0t: %s", $time, why);
		$display("Simulation failed");
		$finish;
	endtask

	task automatic checkWord(input string what, input word_t got, input word_t exp);
		assert (got === exp) else begin
			errCount++;
			$display("error %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkLevel(input string what, input logic got, input logic exp);
		assert (got === exp) else begin
			errCount++;
			$display("error %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic nextCycle();
		@(posedge CLK);
		#1;   // Drive and sample away from the edge
	endtask

	task automatic waitDtack(input logic level);
		int cycles = 0;
		do begin
			nextCycle();
			cycles++;
		end while (dtackN !== level && cycles < timeoutCycles);
		if (dtackN !== level) abortRun($sformatf("timeout waiting for dtackN to be %b", level));
	endtask

	task automatic mdWrite(input regOff_t off, input word_t data);
		va = off;
		vdi = data;
		mdSel = 1'b1;
		asN = 1'b0;
		lwrN = 1'b0;
		uwrN = 1'b0;
		waitDtack(1'b0);
		asN = 1'b1;
		lwrN = 1'b1;
		uwrN = 1'b1;
		mdSel = 1'b0;
		waitDtack(1'b1);
		case (off)
			`DREQ_OFF_DCR: begin
				expDcr = data & `DREQ_DCR_MASK;
				if (!data[`DREQ_DCR_M68S]) fifoModel.delete();   // Flush
			end
			`DREQ_OFF_DLR: expDlr = data & `DREQ_DLR_MASK;
			`DREQ_OFF_FIFO: begin
				if (expDcr[`DREQ_DCR_M68S] && fifoModel.size() < `DREQ_FIFO_DEPTH) begin
					fifoModel.push_back(data);
					expDlr = expDlr - 16'd1;
					if (expDlr == '0) expDcr[`DREQ_DCR_M68S] = 1'b0;
				end
			end
			default: ;
		endcase
	endtask

	task automatic mdRead(input regOff_t off, output word_t data);
		va = off;
		mdSel = 1'b1;
		asN = 1'b0;
		cas0N = 1'b0;
		waitDtack(1'b0);
		data = vdo;
		asN = 1'b1;
		cas0N = 1'b1;
		mdSel = 1'b0;
		waitDtack(1'b1);
	endtask

	// No SH2 ack, data is valid one cycle after the strobe
	task automatic shRead(input regOff_t off, output word_t data);
		shA = off;
		shSel = 1'b1;
		shRdN = 1'b0;
		nextCycle();
		data = shDo;
		shRdN = 1'b1;
		shSel = 1'b0;
		nextCycle();
	endtask

	task automatic popCheck();
		word_t r;
		shRead(`DREQ_OFF_FIFO, r);
		checkWord("SH2 FIFO", r, fifoModel.pop_front());
	endtask

	task automatic reportTest(input string name, input int startErr);
		testCount++;
		$display("test %0d %s: %0d errors", testCount, name, errCount - startErr);
	endtask

	initial begin
		word_t w;
		word_t r;
		int startErr;
		RST_N = 1'b0;
		va = '0;
		vdi = '0;
		asN = 1'b1;
		lwrN = 1'b1;
		uwrN = 1'b1;
		cas0N = 1'b1;
		mdSel = 1'b0;
		shSel = 1'b0;
		shA = '0;
		shRdN = 1'b1;
		repeat (8) @(posedge CLK);
		#1 RST_N = 1'b1;

		startErr = errCount;
		checkLevel("dtackN after reset", dtackN, 1'b1);
		checkLevel("dreq0N after reset", dreq0N, 1'b1);
		mdRead(`DREQ_OFF_DLR, r);
		checkWord("68000 DLR after reset", r, 16'h0000);
		reportTest("reset and DTACK", startErr);

		startErr = errCount;
		foreach (regOffs[i]) begin
			randWord(w);
			mdWrite(regOffs[i], w);
			mdRead(regOffs[i], r);
			checkWord($sformatf("68000 offset %h", regOffs[i]), r, regExpect(regOffs[i], w, 0));
			shRead(regOffs[i], r);
			checkWord($sformatf("SH2 offset %h", regOffs[i]), r, regExpect(regOffs[i], w, 1));
		end
		reportTest("register round trip", startErr);

		startErr = errCount;
		mdWrite(`DREQ_OFF_DCR, 16'h0006);   // DMA and M68S
		mdWrite(`DREQ_OFF_DLR, 16'd6);
		repeat (6) begin
			randWord(w);
			mdWrite(`DREQ_OFF_FIFO, w);
		end
		mdRead(`DREQ_OFF_DCR, r);
		checkWord("68000 DCR after last write", r, mdStatus());
		mdRead(`DREQ_OFF_DLR, r);
		checkWord("68000 DLR after last write", r, expDlr);
		repeat (6) popCheck();
		reportTest("DMA data path", startErr);

		startErr = errCount;
		mdWrite(`DREQ_OFF_DCR, 16'h0006);
		mdWrite(`DREQ_OFF_DLR, 16'd8);
		repeat (4) begin
			randWord(w);
			mdWrite(`DREQ_OFF_FIFO, w);
		end
		checkLevel("dreq0N one cycle after fourth write", dreq0N, 1'b1);
		nextCycle();
		checkLevel("dreq0N two cycles after fourth write", dreq0N, 1'b0);
		popCheck();
		checkLevel("dreq0N below threshold", dreq0N, 1'b1);
		repeat (3) popCheck();
		mdWrite(`DREQ_OFF_DCR, 16'h0004);   // M68S only, no flush
		repeat (4) begin
			randWord(w);
			mdWrite(`DREQ_OFF_FIFO, w);
		end
		for (int i = 0; i < 4; i++) begin
			nextCycle();
			checkLevel("dreq0N with DMA clear", dreq0N, 1'b1);
		end
		repeat (4) popCheck();
		reportTest("DREQ0 level", startErr);

		startErr = errCount;
		mdWrite(`DREQ_OFF_DCR, 16'h0006);
		mdWrite(`DREQ_OFF_DLR, 16'd20);
		repeat (9) begin
			randWord(w);
			mdWrite(`DREQ_OFF_FIFO, w);
		end
		mdRead(`DREQ_OFF_DLR, r);
		checkWord("68000 DLR after write to full FIFO", r, expDlr);
		mdRead(`DREQ_OFF_DCR, r);
		checkWord("68000 DCR when full", r, mdStatus());
		shRead(`DREQ_OFF_DCR, r);
		checkWord("SH2 status when full", r, shStatus());
		checkLevel("dreq0N when full", dreq0N, 1'b0);
		mdWrite(`DREQ_OFF_DCR, 16'h0002);
		shRead(`DREQ_OFF_DCR, r);
		checkWord("SH2 status after flush", r, shStatus());
		checkLevel("dreq0N after flush", dreq0N, 1'b1);
		reportTest("full and flush", startErr);

		$display("tests %0d, errors %0d", testCount, errCount);
		if (errCount == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+src
src/dreqPkg.sv
src/mdDreqRegs.sv
src/dreqFifo.sv
src/shDreqPort.sv
src/dreqTop.sv
verif/tbDreq.sv

//--- Bender.yml
package:
  name: dreq

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/dreqPkg.sv
      - src/mdDreqRegs.sv
      - src/dreqFifo.sv
      - src/shDreqPort.sv
      - src/dreqTop.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/tbDreq.sv
